//--- rtl/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [4:0] {
        ADD   = 5'd0,  AND   = 5'd1,  OR    = 5'd2,  SLL   = 5'd3,
        SRL   = 5'd4,  SLT   = 5'd5,  SLTU  = 5'd6,  SRA   = 5'd7,
        SUB   = 5'd8,  XOR   = 5'd9,  BEQ   = 5'd10, BGE   = 5'd11,
        BNE   = 5'd12, BGEU  = 5'd13, LUI   = 5'd14, AUIPC = 5'd15,
        JAL   = 5'd16, JALR  = 5'd17, LB    = 5'd18, LH    = 5'd19,
        LW    = 5'd20, LBU   = 5'd21, LHU   = 5'd22, SB    = 5'd23,
        SH    = 5'd24, SW    = 5'd25, BLT   = 5'd26, BLTU  = 5'd27,
        JAL_C = 5'd28,
        ILLEGAL = 5'b11111
    } op_e;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [2:0] F3_ADD  = 3'b000; // add, sub.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101; // srl, sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [1:0] {
        Q0     = 2'b00,
        Q1     = 2'b01,
        Q2     = 2'b10,
        UNCOMP = 2'b11
    } quad_e;

    localparam reg_idx_t rvc_base_reg = 5'd8; // x8..x15 for 3-bit fields.

endpackage

//--- rtl/decode_pkg.sv
package decode_pkg;
    import isa_pkg::*;

    typedef logic [xlen-1:0] instr_t; // compressed forms in the low half.

    typedef struct packed {
        op_e             op;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        logic [xlen-1:0] imm;
        logic            has_imm;
    } decoded_t;

    localparam decoded_t dec_illegal = '{
        op:      ILLEGAL,
        rs1:     5'd0,
        rs2:     5'd0,
        rd:      5'd0,
        imm:     '0,
        has_imm: 1'b0
    };

endpackage

//--- rtl/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_ready,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data
);

    logic take;

    // empty, or the held item leaves this cycle.
    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= in_data;
        end
    end

    // a stalled item must not move or change.
    hold_under_stall: assert property (
        @(posedge clk) disable iff (!rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe_stage: output changed while stalled");

endmodule

//--- rtl/rvc_decoder.sv
module rvc_decoder
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [15:0] instr,
    output decoded_t    dec
);

    logic [2:0]      funct3;
    reg_idx_t        full_rd;   // bits 11:7.
    reg_idx_t        full_rs2;  // bits 6:2.
    reg_idx_t        prime_hi;  // bits 9:7 mapped.
    reg_idx_t        prime_lo;  // bits 4:2 mapped.
    logic            nz_imm;
    logic [xlen-1:0] imm_ci;
    logic [xlen-1:0] imm_shamt;
    logic [xlen-1:0] imm_lsw;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_16sp;
    logic [xlen-1:0] imm_lui;

    function automatic reg_idx_t prime_reg(input logic [2:0] field);
        return rvc_base_reg + reg_idx_t'(field);
    endfunction

    assign funct3   = instr[15:13];
    assign full_rd  = instr[11:7];
    assign full_rs2 = instr[6:2];
    assign prime_hi = prime_reg(instr[9:7]);
    assign prime_lo = prime_reg(instr[4:2]);
    assign nz_imm   = |{instr[12], instr[6:2]};

    assign imm_ci    = {{26{instr[12]}}, instr[12], instr[6:2]};
    assign imm_shamt = {26'b0, instr[12], instr[6:2]};
    assign imm_lsw   = {25'b0, instr[5], instr[12:10], instr[6], 2'b00};
    assign imm_j     = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7],
                        instr[2], instr[11], instr[5:3], 1'b0};
    assign imm_16sp  = {{23{instr[12]}}, instr[4:3], instr[5], instr[2], instr[6], 4'b0};
    assign imm_lui   = {{15{instr[12]}}, instr[6:2], 12'b0};

    always_comb begin
        dec = dec_illegal;
        case (quad_e'(instr[1:0]))
            Q0: begin
                if (funct3 == 3'b010) begin // c.lw
                    dec.op      = LW;
                    dec.rd      = prime_lo;
                    dec.rs1     = prime_hi;
                    dec.imm     = imm_lsw;
                    dec.has_imm = 1'b1;
                end else if (funct3 == 3'b110) begin // c.sw
                    dec.op      = SW;
                    dec.rs1     = prime_hi;
                    dec.rs2     = prime_lo;
                    dec.imm     = imm_lsw;
                    dec.has_imm = 1'b1;
                end
            end
            Q1: begin
                case (funct3)
                    3'b000: begin // c.addi
                        dec.op      = ADD;
                        dec.rd      = full_rd;
                        dec.rs1     = full_rd;
                        dec.imm     = imm_ci;
                        dec.has_imm = 1'b1;
                    end
                    3'b001: begin
                        dec.op      = JAL_C;
                        dec.rd      = 5'd1;
                        dec.imm     = imm_j;
                        dec.has_imm = 1'b1;
                    end
                    3'b011: begin
                        if (full_rd == 5'd2 && nz_imm) begin // c.addi16sp
                            dec.op      = ADD;
                            dec.rd      = 5'd2;
                            dec.rs1     = 5'd2;
                            dec.imm     = imm_16sp;
                            dec.has_imm = 1'b1;
                        end else if (full_rd != 5'd2 && full_rd != '0 && nz_imm) begin
                            dec.op      = LUI;
                            dec.rd      = full_rd;
                            dec.imm     = imm_lui;
                            dec.has_imm = 1'b1;
                        end
                    end
                    3'b100: begin
                        if (instr[11:10] != 2'b11) begin
                            dec.op      = (instr[11:10] == 2'b10) ? AND :
                                          (instr[10] ? SRA : SRL);
                            dec.rd      = prime_hi;
                            dec.rs1     = prime_hi;
                            dec.imm     = instr[11] ? imm_ci : imm_shamt;
                            dec.has_imm = 1'b1;
                        end else if (!instr[12]) begin
                            case (instr[6:5])
                                2'b00:   dec.op = SUB;
                                2'b01:   dec.op = XOR;
                                2'b10:   dec.op = OR;
                                default: dec.op = AND;
                            endcase
                            dec.rd  = prime_hi;
                            dec.rs1 = prime_hi;
                            dec.rs2 = prime_lo;
                        end
                    end
                    default: ;
                endcase
            end
            Q2: begin
                if (funct3 == 3'b000) begin // c.slli
                    dec.op      = SLL;
                    dec.rd      = full_rd;
                    dec.rs1     = full_rd;
                    dec.imm     = imm_shamt;
                    dec.has_imm = 1'b1;
                end else if (funct3 == 3'b100) begin
                    if (full_rs2 != '0) begin // c.mv or c.add.
                        dec.op  = ADD;
                        dec.rd  = full_rd;
                        dec.rs1 = instr[12] ? full_rd : 5'd0;
                        dec.rs2 = full_rs2;
                    end else if (full_rd != '0) begin // c.jr or c.jalr.
                        dec.op  = JALR;
                        dec.rd  = instr[12] ? 5'd1 : 5'd0;
                        dec.rs1 = full_rd;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/rv32_decoder.sv
module rv32_decoder
    import isa_pkg::*;
    import decode_pkg::*;
(
    input  instr_t   instr,
    output decoded_t dec
);

    decoded_t        rvc_dec;
    decoded_t        base_dec;
    logic            bad;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt_f7;    // only bit 30 set.
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_shamt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt_f7 = (funct7 == 7'b0100000);

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u     = {instr[31:12], 12'b0};
    assign imm_j     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_shamt = {27'b0, instr[24:20]};

    rvc_decoder rvc_decoder_inst (
        .instr (instr[15:0]),
        .dec   (rvc_dec)
    );

    always_comb begin
        base_dec    = '0;
        base_dec.op = ILLEGAL;
        bad         = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                base_dec.op      = (opcode == OPC_LUI) ? LUI : AUIPC;
                base_dec.rd      = instr[11:7];
                base_dec.imm     = imm_u;
                base_dec.has_imm = 1'b1;
            end
            OPC_JAL: begin
                base_dec.op      = JAL;
                base_dec.rd      = instr[11:7];
                base_dec.imm     = imm_j;
                base_dec.has_imm = 1'b1;
            end
            OPC_JALR: begin
                base_dec.op      = JALR;
                base_dec.rd      = instr[11:7];
                base_dec.rs1     = instr[19:15];
                base_dec.imm     = imm_i;
                base_dec.has_imm = 1'b1;
                bad              = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  base_dec.op = BEQ;
                    F3_BNE:  base_dec.op = BNE;
                    F3_BLT:  base_dec.op = BLT;
                    F3_BGE:  base_dec.op = BGE;
                    F3_BLTU: base_dec.op = BLTU;
                    F3_BGEU: base_dec.op = BGEU;
                    default: bad = 1'b1;
                endcase
                base_dec.rs1     = instr[19:15];
                base_dec.rs2     = instr[24:20];
                base_dec.imm     = imm_b;
                base_dec.has_imm = 1'b1;
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   base_dec.op = LB;
                    F3_LH:   base_dec.op = LH;
                    F3_LW:   base_dec.op = LW;
                    F3_LBU:  base_dec.op = LBU;
                    F3_LHU:  base_dec.op = LHU;
                    default: bad = 1'b1;
                endcase
                base_dec.rd      = instr[11:7];
                base_dec.rs1     = instr[19:15];
                base_dec.imm     = imm_i;
                base_dec.has_imm = 1'b1;
            end
            OPC_STORE: begin
                case (funct3)
                    F3_SB:   base_dec.op = SB;
                    F3_SH:   base_dec.op = SH;
                    F3_SW:   base_dec.op = SW;
                    default: bad = 1'b1;
                endcase
                base_dec.rs1     = instr[19:15];
                base_dec.rs2     = instr[24:20];
                base_dec.imm     = imm_s;
                base_dec.has_imm = 1'b1;
            end
            OPC_OP_IMM: begin
                base_dec.rd      = instr[11:7];
                base_dec.rs1     = instr[19:15];
                base_dec.imm     = imm_i;
                base_dec.has_imm = 1'b1;
                case (funct3)
                    F3_ADD:  base_dec.op = ADD;
                    F3_SLT:  base_dec.op = SLT;
                    F3_SLTU: base_dec.op = SLTU;
                    F3_XOR:  base_dec.op = XOR;
                    F3_OR:   base_dec.op = OR;
                    F3_AND:  base_dec.op = AND;
                    F3_SLL: begin
                        base_dec.op  = SLL;
                        base_dec.imm = imm_shamt;
                        bad          = (funct7 != '0);
                    end
                    default: begin // F3_SRL, srai when bit 30 set.
                        base_dec.op  = instr[30] ? SRA : SRL;
                        base_dec.imm = imm_shamt;
                        bad          = (funct7 != '0) && !alt_f7;
                    end
                endcase
            end
            OPC_OP: begin
                base_dec.rd  = instr[11:7];
                base_dec.rs1 = instr[19:15];
                base_dec.rs2 = instr[24:20];
                case (funct3)
                    F3_ADD:  base_dec.op = instr[30] ? SUB : ADD;
                    F3_SLL:  base_dec.op = SLL;
                    F3_SLT:  base_dec.op = SLT;
                    F3_SLTU: base_dec.op = SLTU;
                    F3_XOR:  base_dec.op = XOR;
                    F3_SRL:  base_dec.op = instr[30] ? SRA : SRL;
                    F3_OR:   base_dec.op = OR;
                    default: base_dec.op = AND;
                endcase
                // bit 30 is only defined for add/sub and srl/sra.
                bad = !((funct7 == '0) ||
                        (alt_f7 && (funct3 == F3_ADD || funct3 == F3_SRL)));
            end
            default: bad = 1'b1;
        endcase
    end

    always_comb begin
        if (instr == '0) begin
            dec = dec_illegal;
        end else if (quad_e'(instr[1:0]) == UNCOMP) begin
            dec = bad ? dec_illegal : base_dec;
        end else begin
            dec = rvc_dec;
        end
    end

    // both decode paths together must cover every known word.
    always_comb begin
        if (!$isunknown(instr)) begin
            assert (!$isunknown(dec.op))
            else $error("rv32_decoder: unknown op for instr %h", instr);
        end
    end

endmodule

//--- rtl/rv_decode_top.sv
module rv_decode_top
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  instr_t   in_instr,
    input  logic     out_ready,
    output logic     in_ready,
    output logic     out_valid,
    output decoded_t out_dec
);

    logic     mid_valid;
    logic     mid_ready;
    instr_t   mid_instr;
    decoded_t mid_dec;

    pipe_stage #(.payload_t(instr_t)) in_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_instr),
        .out_ready (mid_ready),
        .in_ready  (in_ready),
        .out_valid (mid_valid),
        .out_data  (mid_instr)
    );

    rv32_decoder rv32_decoder_inst (
        .instr (mid_instr),
        .dec   (mid_dec)
    );

    pipe_stage #(.payload_t(decoded_t)) out_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mid_valid),
        .in_data   (mid_dec),
        .out_ready (out_ready),
        .in_ready  (mid_ready),
        .out_valid (out_valid),
        .out_data  (out_dec)
    );

endmodule

//--- bench/tb_rv_decode.sv
module tb_rv_decode
    import isa_pkg::*;
    import decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_stream = 100;
    localparam int n_random = 300;
    localparam int n_total  = n_stream + n_random;
    localparam int limit    = 4 * n_total + 200;

    logic     clk;
    logic     rst;
    logic     in_valid;
    instr_t   in_instr;
    logic     out_ready;
    logic     in_ready;
    logic     out_valid;
    decoded_t out_dec;

    decoded_t exp_mem [0:1023];
    int       acc_cyc [0:1023];
    int       rd_ptr;
    int       wr_ptr;
    int       cycle;
    int       issued;
    int       field_errs;
    int       other_errs;
    logic     stream;      // latency checked only in the steady stream.
    logic     holding;
    logic     acc_pend;
    logic     pop_pend;
    instr_t   pend_w;
    decoded_t pend_e;
    decoded_t head;
    int       head_cyc;
    logic     take_out;

    rv_decode_top rv_decode_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_dec   (out_dec)
    );

    assign head     = exp_mem[rd_ptr];
    assign head_cyc = acc_cyc[rd_ptr];
    assign take_out = out_valid && out_ready;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_field(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        field_errs++;
        $display("FAIL %s expected %h actual %h", name, exp_v, got_v);
    endtask

    // builds one instruction word and the record the ISA defines for it.
    task automatic make_case(input int kind, output instr_t w, output decoded_t e);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  r1c;
        logic [2:0]  r2c;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [5:0]  i6;
        logic [11:0] i12;
        logic [12:0] b13;
        logic [20:0] j21;
        logic [19:0] u20;
        logic [9:0]  sp10;
        logic [11:0] cj;
        logic [6:0]  uw;
        int          sel;
        rd   = 5'($urandom);
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        r1c  = 3'($urandom);
        r2c  = 3'($urandom);
        i6   = 6'($urandom);
        i12  = 12'($urandom);
        b13  = 13'($urandom) & ~13'd1;
        j21  = 21'($urandom) & ~21'd1;
        u20  = 20'($urandom);
        cj   = 12'($urandom) & ~12'd1;
        uw   = {i6[4:0], 2'b00};
        sel  = int'($urandom % 10);
        f7   = 7'b0;
        w    = '0;
        e    = '0;
        case (kind)
            0, 1: begin
                w     = {u20, rd, (kind == 0) ? OPC_LUI : OPC_AUIPC};
                e.op  = (kind == 0) ? LUI : AUIPC;
                e.rd  = rd;
                e.imm = {u20, 12'b0};
            end
            2: begin
                w     = {j21[20], j21[10:1], j21[11], j21[19:12], rd, OPC_JAL};
                e.op  = JAL;
                e.rd  = rd;
                e.imm = {{11{j21[20]}}, j21};
            end
            3, 5: begin // jalr and loads share the I format.
                sel = sel % 5;
                f3  = (kind == 3) ? 3'b000 : ((sel < 3) ? 3'(sel) : 3'(sel + 1));
                w   = {i12, rs1, f3, rd, (kind == 3) ? OPC_JALR : OPC_LOAD};
                e.op = (kind == 3) ? JALR : (sel == 0) ? LB : (sel == 1) ? LH :
                       (sel == 2) ? LW : (sel == 3) ? LBU : LHU;
                e.rd  = rd;
                e.rs1 = rs1;
                e.imm = {{20{i12[11]}}, i12};
            end
            4: begin
                sel  = sel % 6;
                f3   = (sel < 2) ? 3'(sel) : 3'(sel + 2);
                w    = {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11], OPC_BRANCH};
                e.op = (sel == 0) ? BEQ : (sel == 1) ? BNE : (sel == 2) ? BLT :
                       (sel == 3) ? BGE : (sel == 4) ? BLTU : BGEU;
                e.rs1 = rs1;
                e.rs2 = rs2;
                e.imm = {{19{b13[12]}}, b13};
            end
            6: begin
                f3    = 3'(sel % 3);
                w     = {i12[11:5], rs2, rs1, f3, i12[4:0], OPC_STORE};
                e.op  = (f3 == 3'd0) ? SB : (f3 == 3'd1) ? SH : SW;
                e.rs1 = rs1;
                e.rs2 = rs2;
                e.imm = {{20{i12[11]}}, i12};
            end
            7: begin
                sel   = sel % 6;
                f3    = (sel == 0) ? 3'd0 : (sel < 4) ? 3'(sel + 1) : 3'(sel + 2);
                w     = {i12, rs1, f3, rd, OPC_OP_IMM};
                e.op  = (sel == 0) ? ADD : (sel == 1) ? SLT : (sel == 2) ? SLTU :
                        (sel == 3) ? XOR : (sel == 4) ? OR : AND;
                e.rd  = rd;
                e.rs1 = rs1;
                e.imm = {{20{i12[11]}}, i12};
            end
            8: begin
                sel   = sel % 3;
                f3    = (sel == 0) ? 3'd1 : 3'd5;
                f7    = (sel == 2) ? 7'h20 : 7'h00;
                w     = {f7, i6[4:0], rs1, f3, rd, OPC_OP_IMM};
                e.op  = (sel == 0) ? SLL : (sel == 1) ? SRL : SRA;
                e.rd  = rd;
                e.rs1 = rs1;
                e.imm = {27'b0, i6[4:0]};
            end
            9: begin
                f3   = (sel < 8) ? 3'(sel) : (sel == 8) ? 3'd0 : 3'd5;
                f7   = (sel >= 8) ? 7'h20 : 7'h00;
                w    = {f7, rs2, rs1, f3, rd, OPC_OP};
                e.op = (sel == 0) ? ADD : (sel == 1) ? SLL : (sel == 2) ? SLT :
                       (sel == 3) ? SLTU : (sel == 4) ? XOR : (sel == 5) ? SRL :
                       (sel == 6) ? OR : (sel == 7) ? AND : (sel == 8) ? SUB : SRA;
                e.rd  = rd;
                e.rs1 = rs1;
                e.rs2 = rs2;
            end
            10, 19: begin // c.addi in Q1, c.slli in Q2.
                w[15:0] = {3'b000, i6[5], rd, i6[4:0], (kind == 10) ? 2'b01 : 2'b10};
                e.op    = (kind == 10) ? ADD : SLL;
                e.rd    = rd;
                e.rs1   = rd;
                e.imm   = (kind == 10) ? {{26{i6[5]}}, i6} : {26'b0, i6};
            end
            11: begin
                w[15:0] = {3'b001, cj[11], cj[4], cj[9:8], cj[10], cj[6], cj[7],
                           cj[3:1], cj[5], 2'b01};
                e.op  = JAL_C;
                e.rd  = 5'd1;
                e.imm = {{20{cj[11]}}, cj};
            end
            12: begin
                if (i6 == 6'd0) i6 = 6'd1;
                sp10    = {i6, 4'b0};
                w[15:0] = {3'b011, sp10[9], 5'd2, sp10[4], sp10[6], sp10[8:7], sp10[5], 2'b01};
                e.op    = ADD;
                e.rd    = 5'd2;
                e.rs1   = 5'd2;
                e.imm   = {{22{sp10[9]}}, sp10};
            end
            13: begin
                if (i6 == 6'd0) i6 = 6'd1;
                if (rd == 5'd0 || rd == 5'd2) rd = 5'd3;
                w[15:0] = {3'b011, i6[5], rd, i6[4:0], 2'b01};
                e.op    = LUI;
                e.rd    = rd;
                e.imm   = {{14{i6[5]}}, i6, 12'b0};
            end
            14, 15: begin // shifts by immediate and c.andi.
                w[15:0] = {3'b100, i6[5], (kind == 15) ? 2'b10 : {1'b0, sel[0]}, r1c,
                           i6[4:0], 2'b01};
                e.op    = (kind == 15) ? AND : (sel[0] ? SRA : SRL);
                e.rd    = 5'd8 + {2'b0, r1c};
                e.rs1   = e.rd;
                e.imm   = (kind == 15) ? {{26{i6[5]}}, i6} : {26'b0, i6};
            end
            16: begin
                w[15:0] = {3'b100, 1'b0, 2'b11, r1c, sel[1:0], r2c, 2'b01};
                e.op    = (sel[1:0] == 2'd0) ? SUB : (sel[1:0] == 2'd1) ? XOR :
                          (sel[1:0] == 2'd2) ? OR : AND;
                e.rd    = 5'd8 + {2'b0, r1c};
                e.rs1   = e.rd;
                e.rs2   = 5'd8 + {2'b0, r2c};
            end
            17, 18: begin // c.lw, c.sw.
                w[15:0] = {(kind == 17) ? 3'b010 : 3'b110, uw[5:3], r1c, uw[2], uw[6],
                           r2c, 2'b00};
                e.op    = (kind == 17) ? LW : SW;
                e.rs1   = 5'd8 + {2'b0, r1c};
                e.rd    = (kind == 17) ? 5'd8 + {2'b0, r2c} : 5'd0;
                e.rs2   = (kind == 18) ? 5'd8 + {2'b0, r2c} : 5'd0;
                e.imm   = {25'b0, uw};
            end
            20: begin
                if (rs1 == 5'd0) rs1 = 5'd1;
                w[15:0] = {3'b100, sel[0], rs1, 5'd0, 2'b10};
                e.op    = JALR;
                e.rd    = sel[0] ? 5'd1 : 5'd0;
                e.rs1   = rs1;
            end
            21: begin
                if (rs2 == 5'd0) rs2 = 5'd1;
                w[15:0] = {3'b100, sel[0], rd, rs2, 2'b10};
                e.op    = ADD;
                e.rd    = rd;
                e.rs1   = sel[0] ? rd : 5'd0;
                e.rs2   = rs2;
            end
            default: begin // 22 zero word, 23 fence/system, 24 bad funct3.
                sel = sel % 3;
                f3  = (sel == 0) ? {2'b01, r1c[0]} : (sel == 1) ? 3'd6 + {2'b0, r1c[0]} :
                      {1'b1, r1c[1:0]};
                if (kind == 23) begin
                    w = {25'($urandom), sel[0] ? 7'b0001111 : 7'b1110011};
                end else if (kind == 24) begin
                    w = {7'($urandom), rs2, rs1, f3, rd, (sel == 0) ? OPC_BRANCH :
                         (sel == 1) ? OPC_LOAD : OPC_STORE};
                end
                e.op = ILLEGAL;
            end
        endcase
        if (e.op inside {LUI, AUIPC, JAL, JAL_C, BEQ, BNE, BLT, BGE, BLTU, BGEU,
                         LB, LH, LW, LBU, LHU, SB, SH, SW} ||
            (e.op == JALR && kind == 3) || kind inside {7, 8, 10, 12, 14, 15, 19}) begin
            e.has_imm = 1'b1;
        end
    endtask

    // settles the last edge and drives on the falling edge.
    task automatic run_cycle(input logic ready, input logic offer, input int kind);
        @(negedge clk);
        if (acc_pend) holding = 1'b0;
        if (pop_pend) rd_ptr++;
        if (!holding && offer && issued < n_total) begin
            make_case(kind, pend_w, pend_e);
            holding = 1'b1;
            issued++;
        end
        in_valid  = holding;
        in_instr  = holding ? pend_w : '0;
        out_ready = ready;
        #1;
        acc_pend = in_valid && in_ready;
        pop_pend = out_valid && out_ready;
        if (acc_pend) begin
            exp_mem[wr_ptr] = pend_e;
            acc_cyc[wr_ptr] = cycle;
            wr_ptr++;
        end
    endtask

    op_ok: assert property (@(posedge clk) disable iff (!rst) take_out |-> out_dec.op == head.op)
        else report_field("out_dec.op", 32'($sampled(head.op)), 32'($sampled(out_dec.op)));
    rs1_ok: assert property (@(posedge clk) disable iff (!rst) take_out |-> out_dec.rs1 == head.rs1)
        else report_field("out_dec.rs1", 32'($sampled(head.rs1)), 32'($sampled(out_dec.rs1)));
    rs2_ok: assert property (@(posedge clk) disable iff (!rst) take_out |-> out_dec.rs2 == head.rs2)
        else report_field("out_dec.rs2", 32'($sampled(head.rs2)), 32'($sampled(out_dec.rs2)));
    rd_ok: assert property (@(posedge clk) disable iff (!rst) take_out |-> out_dec.rd == head.rd)
        else report_field("out_dec.rd", 32'($sampled(head.rd)), 32'($sampled(out_dec.rd)));
    imm_ok: assert property (@(posedge clk) disable iff (!rst) take_out |-> out_dec.imm == head.imm)
        else report_field("out_dec.imm", $sampled(head.imm), $sampled(out_dec.imm));
    has_imm_ok: assert property (@(posedge clk) disable iff (!rst)
        take_out |-> out_dec.has_imm == head.has_imm)
        else report_field("out_dec.has_imm", 32'($sampled(head.has_imm)),
                          32'($sampled(out_dec.has_imm)));
    latency_ok: assert property (@(posedge clk) disable iff (!rst)
        stream && take_out |-> cycle == head_cyc + 2)
        else report_field("latency", 32'($sampled(head_cyc) + 2), 32'($sampled(cycle)));
    one_per_cycle: assert property (@(posedge clk) disable iff (!rst)
        stream && take_out |=> out_valid)
        else begin
            other_errs++;
            $display("result stream had a gap while out_ready was held high");
        end

    no_extra_out: assert property (@(posedge clk) disable iff (!rst) take_out |-> rd_ptr < wr_ptr)
        else begin
            other_errs++;
            $display("output transfer with no pending instruction");
        end
    full_stalls_input: assert property (@(posedge clk) disable iff (!rst)
        rv_decode_top_inst.mid_valid && out_valid && !out_ready |-> !in_ready)
        else begin
            other_errs++;
            $display("in_ready stayed high while both stages were full");
        end
    reset_state: assert property (@(posedge clk) $rose(rst) |-> !out_valid && in_ready)
        else begin
            other_errs++;
            $display("wrong handshake state right after reset");
        end

    initial begin
        wait (cycle >= limit);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(17292));
        rst        = 1'b0;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_ready  = 1'b0;
        cycle      = 0;
        rd_ptr     = 0;
        wr_ptr     = 0;
        issued     = 0;
        field_errs = 0;
        other_errs = 0;
        stream     = 1'b0;
        holding    = 1'b0;
        acc_pend   = 1'b0;
        pop_pend   = 1'b0;
        repeat (3) @(negedge clk);
        rst    = 1'b1;
        stream = 1'b1;
        for (int k = 0; k < n_stream; k++) begin
            run_cycle(1'b1, 1'b1, k % 25);
        end
        stream = 1'b0;
        while (issued < n_total) begin
            run_cycle(1'($urandom), ($urandom % 4) != 0, int'($urandom % 25));
        end
        while (holding || pop_pend || rd_ptr != wr_ptr) begin
            run_cycle(1'b1, 1'b0, 0);
        end
        repeat (2) @(negedge clk);
        assert (rd_ptr == n_total && wr_ptr == n_total)
        else begin
            other_errs++;
            $display("instructions lost: issued %0d, accepted %0d, returned %0d",
                     issued, wr_ptr, rd_ptr);
        end
        $display("field errors: %0d, other errors: %0d", field_errs, other_errs);
        if (field_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/isa_pkg.sv
rtl/decode_pkg.sv
rtl/pipe_stage.sv
rtl/rvc_decoder.sv
rtl/rv32_decoder.sv
rtl/rv_decode_top.sv
bench/tb_rv_decode.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_rv_decode -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
